// ==== src/isaPkg.sv ====
/* instruction-set constants for the reduced 6502 subset
   opcodes are the standard NMOS values; anything else decodes as NOP */
package isaPkg;

  typedef logic [7:0]  byteT;
  typedef logic [15:0] addrT;

  // immediate operand group
  localparam byteT opLdaImm = 8'hA9;
  localparam byteT opLdxImm = 8'hA2;
  localparam byteT opLdyImm = 8'hA0;
  localparam byteT opAdcImm = 8'h69;
  localparam byteT opAndImm = 8'h29;
  localparam byteT opOraImm = 8'h09;
  localparam byteT opEorImm = 8'h49;

  // implied, two cycles each
  localparam byteT opInx = 8'hE8;
  localparam byteT opIny = 8'hC8;
  localparam byteT opDex = 8'hCA;
  localparam byteT opDey = 8'h88;
  localparam byteT opTax = 8'hAA;
  localparam byteT opTay = 8'hA8;
  localparam byteT opTxa = 8'h8A;
  localparam byteT opTya = 8'h98;
  localparam byteT opClc = 8'h18;
  localparam byteT opSec = 8'h38;
  localparam byteT opNop = 8'hEA;

  // absolute addressing
  localparam byteT opStaAbs = 8'h8D;
  localparam byteT opJmpAbs = 8'h4C;

  localparam addrT resetVector = 16'hFFFC;

  // index 0 is X, index 1 is Y
  localparam int numIndex = 2;

endpackage

// ==== src/controlPkg.sv ====
/* control encodings passed from the decoder into the datapath
   timing states cover reset vector fetch and the absolute-mode cycles only */
package controlPkg;

  // decoder cycle state
  typedef enum logic [2:0] {
    tReset0,
    tReset1,
    tFetch,
    tOperand,
    tAbsLo,
    tAbsHi,
    tWrite
  } timingT;

  // aluPass loads sb into the accumulator unchanged
  typedef enum logic [2:0] {
    aluPass,
    aluAdd,
    aluAnd,
    aluOr,
    aluEor
  } aluOpT;

  // internal bus driver
  typedef enum logic [1:0] {
    srcData,
    srcAcc,
    srcX,
    srcY
  } busSrcT;

  // address bus source
  typedef enum logic [1:0] {
    addrPc,
    addrOperand,
    addrVector
  } addrSrcT;

endpackage

// ==== src/indexRegister.sv ====
/* 8-bit index register, increment and decrement wrap modulo 256
   load has priority over the counting strobes */
`timescale 1ns/1ps

module indexRegister (
  input  logic         phi2,
  input  logic         rstN,
  input  logic         rdy,
  input  isaPkg::byteT sb,
  input  logic         load,
  input  logic         inc,
  input  logic         dec,
  output isaPkg::byteT value
);

  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      value <= 8'h00;
    end else if (rdy) begin
      if (load) begin
        value <= sb;
      end else if (inc) begin
        value <= value + 8'd1;
      end else if (dec) begin
        value <= value - 8'd1;
      end
    end
  end

endmodule

// ==== src/internalBus.sv ====
/* internal bus selector for loads and register transfers
   purely combinational, no precharge modelling */
`timescale 1ns/1ps

module internalBus (
  input  controlPkg::busSrcT busSrc,
  input  isaPkg::byteT       dataIn,
  input  isaPkg::byteT       acc,
  input  isaPkg::byteT       xValue,
  input  isaPkg::byteT       yValue,
  output isaPkg::byteT       sb
);
  import controlPkg::*;

  always_comb begin
    case (busSrc)
      srcData: sb = dataIn;
      srcAcc:  sb = acc;
      srcX:    sb = xValue;
      srcY:    sb = yValue;
      default: sb = dataIn;
    endcase
  end

endmodule

// ==== src/aluAccum.sv ====
/* accumulator with binary add and logic ops; carry is the only flag kept
   only the add updates carry, besides CLC and SEC */
`timescale 1ns/1ps

module aluAccum (
  input  logic              phi2,
  input  logic              rstN,
  input  logic              rdy,
  input  isaPkg::byteT      sb,
  input  controlPkg::aluOpT aluOp,
  input  logic              accLoad,
  input  logic              carrySet,
  input  logic              carryClear,
  output isaPkg::byteT      acc
);
  import isaPkg::*;
  import controlPkg::*;

  logic       carry;
  logic [8:0] sum;
  byteT       aluResult;

  always_comb begin
    sum = {1'b0, acc} + {1'b0, sb} + {8'd0, carry};
    case (aluOp)
      aluPass: aluResult = sb;
      aluAdd:  aluResult = sum[7:0];
      aluAnd:  aluResult = acc & sb;
      aluOr:   aluResult = acc | sb;
      aluEor:  aluResult = acc ^ sb;
      default: aluResult = sb;
    endcase
  end

  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      acc   <= 8'h00;
      carry <= 1'b0;
    end else if (rdy) begin
      if (accLoad) begin
        acc <= aluResult;
      end
      // carry out of bit 7
      if (accLoad && aluOp == aluAdd) begin
        carry <= sum[8];
      end else if (carrySet) begin
        carry <= 1'b1;
      end else if (carryClear) begin
        carry <= 1'b0;
      end
    end
  end

endmodule

// ==== src/addressUnit.sv ====
/* program counter, operand latches and address bus mux
   pcLoad sees a byte being latched in the same cycle, so JMP needs no extra cycle */
`timescale 1ns/1ps

module addressUnit (
  input  logic                phi2,
  input  logic                rstN,
  input  logic                rdy,
  input  isaPkg::byteT        dataIn,
  input  logic                pcInc,
  input  logic                pcLoad,
  input  logic                loLatch,
  input  logic                hiLatch,
  input  controlPkg::addrSrcT addrSel,
  output isaPkg::addrT        addressBus
);
  import isaPkg::*;
  import controlPkg::*;

  addrT pc;
  byteT opLo;
  byteT opHi;
  addrT operandNext;

  // high byte arrives on dataIn in the cycle that loads the counter
  assign operandNext = {dataIn, opLo};

  always_ff @(posedge phi2) begin
    if (rdy && loLatch) begin
      opLo <= dataIn;
    end
    if (rdy && hiLatch) begin
      opHi <= dataIn;
    end
  end

  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      pc <= 16'h0000;
    end else if (rdy) begin
      if (pcLoad) begin
        pc <= operandNext;
      end else if (pcInc) begin
        pc <= pc + 16'd1;
      end
    end
  end

  // vector low bit follows hiLatch to give FFFC then FFFD
  always_comb begin
    case (addrSel)
      addrOperand: addressBus = {opHi, opLo};
      addrVector:  addressBus = resetVector | addrT'(hiLatch);
      default:     addressBus = pc;
    endcase
  end

endmodule

// ==== src/instructionDecode.sv ====
/* cycle state machine and decoder, strobes apply to the current cycle only
   unsupported opcodes run as a two-cycle NOP */
`timescale 1ns/1ps

module instructionDecode (
  input  logic                        phi2,
  input  logic                        rstN,
  input  logic                        rdy,
  input  isaPkg::byteT                dataIn,
  output controlPkg::aluOpT           aluOp,
  output controlPkg::busSrcT          busSrc,
  output logic                        accLoad,
  output logic                        carrySet,
  output logic                        carryClear,
  output logic [isaPkg::numIndex-1:0] idxLoad,
  output logic [isaPkg::numIndex-1:0] idxInc,
  output logic [isaPkg::numIndex-1:0] idxDec,
  output logic                        pcInc,
  output logic                        pcLoad,
  output logic                        loLatch,
  output logic                        hiLatch,
  output controlPkg::addrSrcT         addrSel,
  output logic                        rw,
  output logic                        sync
);
  import isaPkg::*;
  import controlPkg::*;

  timingT state;
  timingT nextState;
  byteT   opcode;

  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      state <= tReset0;
    end else if (rdy) begin
      state <= nextState;
    end
  end

  always_ff @(posedge phi2) begin
    if (rdy && state == tFetch) begin
      opcode <= dataIn;
    end
  end

  always_comb begin
    aluOp      = aluPass;
    busSrc     = srcData;
    accLoad    = 1'b0;
    carrySet   = 1'b0;
    carryClear = 1'b0;
    idxLoad    = '0;
    idxInc     = '0;
    idxDec     = '0;
    pcInc      = 1'b0;
    pcLoad     = 1'b0;
    loLatch    = 1'b0;
    hiLatch    = 1'b0;
    addrSel    = addrPc;
    rw         = 1'b1;
    sync       = 1'b0;
    nextState  = state;
    case (state)
      tReset0: begin
        addrSel   = addrVector;
        loLatch   = 1'b1;
        nextState = tReset1;
      end
      // hiLatch also selects FFFD on the vector address
      tReset1: begin
        addrSel   = addrVector;
        hiLatch   = 1'b1;
        pcLoad    = 1'b1;
        nextState = tFetch;
      end
      tFetch: begin
        sync  = 1'b1;
        pcInc = 1'b1;
        if (dataIn == opStaAbs || dataIn == opJmpAbs) begin
          nextState = tAbsLo;
        end else begin
          nextState = tOperand;
        end
      end
      tOperand: begin
        nextState = tFetch;
        case (opcode)
          opLdaImm: begin
            pcInc   = 1'b1;
            accLoad = 1'b1;
          end
          opLdxImm: begin
            pcInc      = 1'b1;
            idxLoad[0] = 1'b1;
          end
          opLdyImm: begin
            pcInc      = 1'b1;
            idxLoad[1] = 1'b1;
          end
          opAdcImm: begin
            pcInc   = 1'b1;
            aluOp   = aluAdd;
            accLoad = 1'b1;
          end
          opAndImm: begin
            pcInc   = 1'b1;
            aluOp   = aluAnd;
            accLoad = 1'b1;
          end
          opOraImm: begin
            pcInc   = 1'b1;
            aluOp   = aluOr;
            accLoad = 1'b1;
          end
          opEorImm: begin
            pcInc   = 1'b1;
            aluOp   = aluEor;
            accLoad = 1'b1;
          end
          opInx: idxInc[0] = 1'b1;
          opIny: idxInc[1] = 1'b1;
          opDex: idxDec[0] = 1'b1;
          opDey: idxDec[1] = 1'b1;
          opTax: begin
            busSrc     = srcAcc;
            idxLoad[0] = 1'b1;
          end
          opTay: begin
            busSrc     = srcAcc;
            idxLoad[1] = 1'b1;
          end
          opTxa: begin
            busSrc  = srcX;
            accLoad = 1'b1;
          end
          opTya: begin
            busSrc  = srcY;
            accLoad = 1'b1;
          end
          opClc: carryClear = 1'b1;
          opSec: carrySet = 1'b1;
          // NOP and everything outside the subset
          default: nextState = tFetch;
        endcase
      end
      tAbsLo: begin
        loLatch   = 1'b1;
        pcInc     = 1'b1;
        nextState = tAbsHi;
      end
      tAbsHi: begin
        hiLatch = 1'b1;
        if (opcode == opJmpAbs) begin
          pcLoad    = 1'b1;
          nextState = tFetch;
        end else begin
          pcInc     = 1'b1;
          nextState = tWrite;
        end
      end
      tWrite: begin
        addrSel   = addrOperand;
        rw        = 1'b0;
        nextState = tFetch;
      end
      default: nextState = tReset0;
    endcase
  end

endmodule

// ==== src/cpu6502Lite.sv ====
/* single-clock 6502 subset core, no interrupts, stack or decimal mode
   memory is external with combinational read data; rw low marks a write cycle */
`timescale 1ns/1ps

module cpu6502Lite (
  input  logic         phi2,
  input  logic         rstN,
  input  logic         rdy,
  input  isaPkg::byteT dataIn,
  output isaPkg::byteT dataOut,
  output isaPkg::addrT addressBus,
  output logic         rw,
  output logic         sync
);
  import isaPkg::*;
  import controlPkg::*;

  aluOpT               aluOp;
  busSrcT              busSrc;
  addrSrcT             addrSel;
  logic                accLoad;
  logic                carrySet;
  logic                carryClear;
  logic [numIndex-1:0] idxLoad;
  logic [numIndex-1:0] idxInc;
  logic [numIndex-1:0] idxDec;
  logic                pcInc;
  logic                pcLoad;
  logic                loLatch;
  logic                hiLatch;
  byteT                sb;
  byteT                acc;
  byteT                idxValue [numIndex];

  assign dataOut = acc;

  instructionDecode instructionDecode_inst (
    .phi2       (phi2),
    .rstN       (rstN),
    .rdy        (rdy),
    .dataIn     (dataIn),
    .aluOp      (aluOp),
    .busSrc     (busSrc),
    .accLoad    (accLoad),
    .carrySet   (carrySet),
    .carryClear (carryClear),
    .idxLoad    (idxLoad),
    .idxInc     (idxInc),
    .idxDec     (idxDec),
    .pcInc      (pcInc),
    .pcLoad     (pcLoad),
    .loLatch    (loLatch),
    .hiLatch    (hiLatch),
    .addrSel    (addrSel),
    .rw         (rw),
    .sync       (sync)
  );

  // X and Y
  for (genvar i = 0; i < numIndex; i++) begin : genIndex
    indexRegister indexRegister_inst (
      .phi2  (phi2),
      .rstN  (rstN),
      .rdy   (rdy),
      .sb    (sb),
      .load  (idxLoad[i]),
      .inc   (idxInc[i]),
      .dec   (idxDec[i]),
      .value (idxValue[i])
    );
  end

  internalBus internalBus_inst (
    .busSrc (busSrc),
    .dataIn (dataIn),
    .acc    (acc),
    .xValue (idxValue[0]),
    .yValue (idxValue[1]),
    .sb     (sb)
  );

  aluAccum aluAccum_inst (
    .phi2       (phi2),
    .rstN       (rstN),
    .rdy        (rdy),
    .sb         (sb),
    .aluOp      (aluOp),
    .accLoad    (accLoad),
    .carrySet   (carrySet),
    .carryClear (carryClear),
    .acc        (acc)
  );

  addressUnit addressUnit_inst (
    .phi2       (phi2),
    .rstN       (rstN),
    .rdy        (rdy),
    .dataIn     (dataIn),
    .pcInc      (pcInc),
    .pcLoad     (pcLoad),
    .loLatch    (loLatch),
    .hiLatch    (hiLatch),
    .addrSel    (addrSel),
    .addressBus (addressBus)
  );

endmodule

// ==== testbench/tbCpu6502Lite.sv ====
/* directed tests for cpu6502Lite; memory reads are combinational and writes are only captured
   each test reloads memory and resets the core, random operands come from $random seeded with 97 */
`timescale 1ns/1ps

module tbCpu6502Lite;
  import isaPkg::*;

  localparam int clkPeriod = 100;
  localparam int resetCycles = 6;
  localparam int vectorLimit = 10;
  localparam int loadsLimit = 120;
  localparam int arithLimit = 80;
  localparam int arithRuns = 20;
  localparam int countLimit = 160;
  localparam int jumpLimit = 300;
  localparam int watchdogCycles = vectorLimit + loadsLimit + arithRuns * arithLimit
                                  + countLimit + jumpLimit + (arithRuns + 4) * resetCycles + 20;
  localparam addrT progOrigin = 16'h0200;

  logic   clk;
  logic   rstN;
  logic   rdy;
  byteT   dataIn;
  byteT   dataOut;
  addrT   addressBus;
  logic   rw;
  logic   sync;
  byteT   mem [0:65535];
  addrT   progPtr;
  addrT   wrAddr [$];
  byteT   wrData [$];
  integer seed;
  int     errorCount;
  int     mismatchCount;

  cpu6502Lite cpu6502Lite_inst (
    .phi2       (clk),
    .rstN       (rstN),
    .rdy        (rdy),
    .dataIn     (dataIn),
    .dataOut    (dataOut),
    .addressBus (addressBus),
    .rw         (rw),
    .sync       (sync)
  );

  assign dataIn = mem[addressBus];

  always #(clkPeriod / 2) clk = ~clk;

  function automatic byteT randomByte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // background pattern and a reset vector pointing at the program
  task automatic startProgram(input addrT origin);
    addrT a;
    for (int i = 0; i < 65536; i++) begin
      a = i[15:0];
      mem[i] = a[15:8] ^ a[7:0];
    end
    mem[resetVector] = origin[7:0];
    mem[resetVector + 16'd1] = origin[15:8];
    progPtr = origin;
  endtask

  task automatic emit(input byteT b);
    mem[progPtr] = b;
    progPtr = progPtr + 16'd1;
  endtask

  task automatic emitImm(input byteT op, input byteT value);
    emit(op);
    emit(value);
  endtask

  task automatic emitAbs(input byteT op, input addrT addr);
    emit(op);
    emit(addr[7:0]);
    emit(addr[15:8]);
  endtask

  task automatic pulseReset();
    @(posedge clk);
    #1;
    rstN = 1'b0;
    rdy = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    wrAddr.delete();
    wrData.delete();
  endtask

  // outputs sampled at the falling edge of every clock
  task automatic runProgram(input string name, input addrT stopAddr, input int maxCycles,
                            input bit stallOn);
    int          n;
    bit          done;
    logic        prevRdy;
    addrT        prevAddr;
    logic        prevRw;
    logic [31:0] r;
    done = 1'b0;
    n = 0;
    prevRdy = 1'b1;
    prevAddr = '0;
    prevRw = 1'b1;
    while (!done && n < maxCycles) begin
      @(negedge clk);
      if (!prevRdy && (addressBus !== prevAddr || rw !== prevRw)) begin
        errorCount++;
        $display("%s: address bus or rw changed while rdy was low", name);
      end
      if (rdy && !rw) begin
        wrAddr.push_back(addressBus);
        wrData.push_back(dataOut);
        if (addressBus == stopAddr) begin
          done = 1'b1;
        end
      end
      prevRdy = rdy;
      prevAddr = addressBus;
      prevRw = rw;
      n++;
      @(posedge clk);
      #1;
      r = $random(seed);
      rdy = stallOn ? (r[1:0] != 2'b00) : 1'b1;
    end
    rdy = 1'b1;
    if (!done) begin
      errorCount++;
      $display("%s: no write to %h within %0d cycles", name, stopAddr, maxCycles);
    end
  endtask

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (actual !== expected) begin
      mismatchCount++;
      $display("mismatch %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic checkWrite(input string name, input int idx, input addrT expAddr,
                            input byteT expData);
    if (idx >= wrAddr.size()) begin
      errorCount++;
      $display("%s: expected write to %h never happened", name, expAddr);
    end else begin
      checkValue({name, " address"}, expAddr, wrAddr[idx]);
      checkValue({name, " data"}, {8'h00, expData}, {8'h00, wrData[idx]});
    end
  endtask

  task automatic checkWriteCount(input string name, input int expected);
    if (wrAddr.size() != expected) begin
      errorCount++;
      $display("%s: saw %0d writes instead of %0d", name, wrAddr.size(), expected);
    end
  endtask

  task automatic vectorFetch();
    addrT vec;
    byteT lo;
    byteT hi;
    bit   seen;
    int   n;
    lo = randomByte();
    hi = randomByte();
    vec = {2'b01, hi[5:0], lo};
    startProgram(vec);
    emit(opNop);
    pulseReset();
    seen = 1'b0;
    n = 0;
    while (!seen && n < vectorLimit) begin
      @(negedge clk);
      if (n == 0) checkValue("vector low read", resetVector, addressBus);
      if (n == 1) checkValue("vector high read", resetVector + 16'd1, addressBus);
      if (sync) begin
        seen = 1'b1;
        checkValue("first fetch address", vec, addressBus);
        checkValue("first fetch cycle", 16'd2, n[15:0]);
      end
      n++;
    end
    if (!seen) begin
      errorCount++;
      $display("vector fetch: sync never went high after reset");
    end
  endtask

  task automatic loadsAndTransfers();
    byteT v [5];
    foreach (v[i]) v[i] = randomByte();
    startProgram(progOrigin);
    emitImm(opLdaImm, v[0]);
    emitAbs(opStaAbs, 16'h0300);
    emitImm(opLdxImm, v[1]);
    emit(opTxa);
    emitAbs(opStaAbs, 16'h0301);
    emitImm(opLdyImm, v[2]);
    emit(opTya);
    emitAbs(opStaAbs, 16'h0302);
    // acc overwritten between transfer and read back
    emitImm(opLdaImm, v[3]);
    emit(opTax);
    emitImm(opLdaImm, ~v[3]);
    emit(opTxa);
    emitAbs(opStaAbs, 16'h0303);
    emitImm(opLdaImm, v[4]);
    emit(opTay);
    emitImm(opLdaImm, ~v[4]);
    emit(opTya);
    emitAbs(opStaAbs, 16'h0304);
    pulseReset();
    runProgram("loads", 16'h0304, loadsLimit, 1'b0);
    checkWriteCount("loads", 5);
    checkWrite("lda", 0, 16'h0300, v[0]);
    checkWrite("ldx txa", 1, 16'h0301, v[1]);
    checkWrite("ldy tya", 2, 16'h0302, v[2]);
    checkWrite("tax txa", 3, 16'h0303, v[3]);
    checkWrite("tay tya", 4, 16'h0304, v[4]);
  endtask

  task automatic arithmeticLogic();
    byteT a;
    byteT b;
    byteT r;
    logic c;
    int   total;
    for (int k = 0; k < arithRuns; k++) begin
      a = randomByte();
      b = randomByte();
      r = randomByte();
      c = r[0];
      startProgram(progOrigin);
      emit(c ? opSec : opClc);
      emitImm(opLdaImm, a);
      emitImm(opAdcImm, b);
      emitAbs(opStaAbs, 16'h0310);
      emitImm(opLdaImm, a);
      emitImm(opAndImm, b);
      emitAbs(opStaAbs, 16'h0311);
      emitImm(opLdaImm, a);
      emitImm(opOraImm, b);
      emitAbs(opStaAbs, 16'h0312);
      emitImm(opLdaImm, a);
      emitImm(opEorImm, b);
      emitAbs(opStaAbs, 16'h0313);
      // 0 + 0 + carry left by the first add
      emitImm(opLdaImm, 8'h00);
      emitImm(opAdcImm, 8'h00);
      emitAbs(opStaAbs, 16'h0314);
      pulseReset();
      runProgram("arithmetic", 16'h0314, arithLimit, 1'b0);
      // carry out whenever the full sum passes 255
      total = int'(a) + int'(b) + int'(c);
      checkWriteCount("arithmetic", 5);
      checkWrite("adc", 0, 16'h0310, byteT'(total % 256));
      checkWrite("and", 1, 16'h0311, a & b);
      checkWrite("ora", 2, 16'h0312, a | b);
      checkWrite("eor", 3, 16'h0313, a ^ b);
      checkWrite("adc carry", 4, 16'h0314, (total > 255) ? 8'h01 : 8'h00);
    end
  endtask

  task automatic indexCounting();
    byteT x0;
    byteT y0;
    x0 = randomByte();
    y0 = randomByte();
    startProgram(progOrigin);
    emitImm(opLdxImm, 8'hFF);
    emit(opInx);
    emit(opTxa);
    emitAbs(opStaAbs, 16'h0320);
    emitImm(opLdyImm, 8'h00);
    emit(opDey);
    emit(opTya);
    emitAbs(opStaAbs, 16'h0321);
    emitImm(opLdxImm, x0);
    repeat (5) emit(opInx);
    emit(opTxa);
    emitAbs(opStaAbs, 16'h0322);
    emitImm(opLdyImm, y0);
    repeat (6) emit(opIny);
    emit(opTya);
    emitAbs(opStaAbs, 16'h0323);
    emitImm(opLdxImm, y0);
    repeat (3) emit(opDex);
    emit(opTxa);
    emitAbs(opStaAbs, 16'h0324);
    pulseReset();
    runProgram("counting", 16'h0324, countLimit, 1'b0);
    checkWriteCount("counting", 5);
    checkWrite("inx wrap", 0, 16'h0320, 8'h00);
    checkWrite("dey wrap", 1, 16'h0321, 8'hFF);
    checkWrite("inx x5", 2, 16'h0322, x0 + 8'd5);
    checkWrite("iny x6", 3, 16'h0323, y0 + 8'd6);
    checkWrite("dex x3", 4, 16'h0324, y0 - 8'd3);
  endtask

  task automatic jumpAndStall();
    byteT v [3];
    foreach (v[i]) v[i] = randomByte();
    startProgram(16'h0400);
    emitImm(opLdaImm, v[0]);
    emitAbs(opStaAbs, 16'h0330);
    emitAbs(opJmpAbs, 16'h0480);
    // skipped by the jump
    emitImm(opLdaImm, 8'hEE);
    emitAbs(opStaAbs, 16'h0331);
    progPtr = 16'h0480;
    emitImm(opLdaImm, v[1]);
    emitAbs(opStaAbs, 16'h0332);
    emitImm(opLdxImm, v[2]);
    emit(opTxa);
    emitAbs(opStaAbs, 16'h0333);
    pulseReset();
    runProgram("jump", 16'h0333, jumpLimit, 1'b1);
    foreach (wrAddr[i]) begin
      if (wrAddr[i] == 16'h0331) begin
        errorCount++;
        $display("jump: store after the JMP was executed");
      end
    end
    checkWriteCount("jump", 3);
    checkWrite("before jmp", 0, 16'h0330, v[0]);
    checkWrite("after jmp", 1, 16'h0332, v[1]);
    checkWrite("after stall", 2, 16'h0333, v[2]);
  endtask

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("watchdog: run exceeded %0d cycles", watchdogCycles);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    rdy = 1'b1;
    seed = 97;
    errorCount = 0;
    mismatchCount = 0;
    startProgram(progOrigin);
    vectorFetch();
    loadsAndTransfers();
    arithmeticLogic();
    indexCounting();
    jumpAndStall();
    $display("done: %0d mismatches, %0d other errors", mismatchCount, errorCount);
    if (mismatchCount == 0 && errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
src/isaPkg.sv
src/controlPkg.sv
src/indexRegister.sv
src/internalBus.sv
src/aluAccum.sv
src/addressUnit.sv
src/instructionDecode.sv
src/cpu6502Lite.sv
testbench/tbCpu6502Lite.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbCpu6502Lite
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf $(BUILD_DIR)
